// ==== project.f ====
+incdir+.
rv_decode_pkg.sv
instr_classify.sv
imm_gen.sv
handshake_fsm.sv
pc_unit.sv
issue_stage.sv
rv_decode_top.sv
decode_checker.sv
tb_rv_decode.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_decode
RTL_TOP    := rv_decode_top
FILELIST   := project.f
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_rv_decode
  import rv_decode_pkg::*;
();

  localparam int NUM_CYCLES     = 3000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  fetch_valid;
  logic                  fetch_ready;
  logic                  exec_ready;
  logic                  decode_valid;
  logic [`RV_XLEN-1:0]   instr;
  logic [`RV_XLEN-1:0]   fetch_pc;
  logic [`RV_XLEN-1:0]   reg_rs1_data;
  logic [`RV_XLEN-1:0]   reg_rs2_data;
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]   next_pc;
  issue_t                issue;
  int                    errors;
  int                    checks;
  int                    cycle_count = 0;

  always #5 clk = ~clk;

  rv_decode_top u_rv_decode_top (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .exec_ready   (exec_ready),
    .decode_valid (decode_valid),
    .instr        (instr),
    .fetch_pc     (fetch_pc),
    .reg_rs1_data (reg_rs1_data),
    .reg_rs2_data (reg_rs2_data),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .next_pc      (next_pc),
    .issue        (issue)
  );

  decode_checker u_decode_checker (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .exec_ready   (exec_ready),
    .instr        (instr),
    .fetch_pc     (fetch_pc),
    .reg_rs1_data (reg_rs1_data),
    .reg_rs2_data (reg_rs2_data),
    .fetch_ready  (fetch_ready),
    .decode_valid (decode_valid),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .next_pc      (next_pc),
    .issue        (issue),
    .errors       (errors),
    .checks       (checks)
  );

  // legal template of a kept class, or now and then a raw word
  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [2:0]  f3;
    int unsigned r;
    w = $urandom();
    if ($urandom_range(0, 99) < 20) begin
      return w;
    end
    f3 = w[14:12];
    case ($urandom_range(0, 8))
      0: begin
        w[6:0] = opc_op;
        // alternate form only for sub and sra
        if ((f3 == 3'b000 || f3 == 3'b101) && w[30]) begin
          w[31:25] = 7'b0100000;
        end else begin
          w[31:25] = 7'b0000000;
        end
      end
      1: begin
        w[6:0] = opc_op_imm;
        if (f3 == 3'b001) begin
          w[31:25] = 7'b0000000;
        end else if (f3 == 3'b101) begin
          w[31:25] = w[30] ? 7'b0100000 : 7'b0000000;
        end
      end
      2: begin
        w[6:0] = opc_load;
        r = $urandom_range(0, 4);
        w[14:12] = (r < 3) ? 3'(r) : 3'(r + 1);
      end
      3: begin
        w[6:0] = opc_store;
        w[14:12] = 3'($urandom_range(0, 2));
      end
      4: w[6:0] = opc_lui;
      5: w[6:0] = opc_auipc;
      6: w[6:0] = opc_jal;
      7: begin
        w[6:0] = opc_jalr;
        w[14:12] = 3'b000;
      end
      default: begin
        w[6:0] = opc_branch;
        r = $urandom_range(0, 5);
        w[14:12] = (r < 2) ? 3'(r) : 3'(r + 2);
      end
    endcase
    return w;
  endfunction

  task automatic drive_inputs();
    logic [31:0] rs1;
    rs1 = $urandom();
    fetch_valid  <= ($urandom_range(0, 99) < 70);
    exec_ready   <= ($urandom_range(0, 99) < 70);
    instr        <= make_instr();
    fetch_pc     <= $urandom() & 32'hffff_fffc;
    reg_rs1_data <= rs1;
    // equal operands so branches go both ways
    if ($urandom_range(0, 99) < 25) begin
      reg_rs2_data <= rs1;
    end else begin
      reg_rs2_data <= $urandom();
    end
  endtask

  initial begin
    void'($urandom(87));
    reset        = 1'b1;
    fetch_valid  = 1'b0;
    exec_ready   = 1'b0;
    instr        = '0;
    fetch_pc     = '0;
    reg_rs1_data = '0;
    reg_rs2_data = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (NUM_CYCLES) begin
      drive_inputs();
      @(posedge clk);
    end
    // one more edge to compare the last captured item
    @(posedge clk);
    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

// ==== decode_checker.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module decode_checker
  import rv_decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_valid,
  input  logic                  exec_ready,
  input  logic [`RV_XLEN-1:0]   instr,
  input  logic [`RV_XLEN-1:0]   fetch_pc,
  input  logic [`RV_XLEN-1:0]   reg_rs1_data,
  input  logic [`RV_XLEN-1:0]   reg_rs2_data,
  input  logic                  fetch_ready,
  input  logic                  decode_valid,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic [`RV_XLEN-1:0]   next_pc,
  input  issue_t                issue,
  output int                    errors,
  output int                    checks
);

  issue_t              exp_issue;
  logic [`RV_XLEN-1:0] exp_npc;
  logic                exp_full;
  logic                exp_dv;
  logic                exp_fr;
  logic                have_expect = 1'b0;
  int                  error_count = 0;
  int                  check_count = 0;

  assign errors = error_count;
  assign checks = check_count;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  function automatic alu_op_e alu_for(input logic [2:0] f3, input logic alt);
    if (f3 == 3'b000) return alt ? alu_sub : alu_add;
    if (f3 == 3'b101) return alt ? alu_sra : alu_srl;
    if (f3 == 3'b001) return alu_sll;
    if (f3 == 3'b010) return alu_slt;
    if (f3 == 3'b011) return alu_sltu;
    if (f3 == 3'b100) return alu_xor;
    if (f3 == 3'b110) return alu_or;
    return alu_and;
  endfunction

  // ISA rules for one word, full is low when only validity is predicted
  task automatic predict_issue(input logic [31:0] w, input logic [31:0] pc,
                               input logic [31:0] rs1, input logic [31:0] rs2,
                               output issue_t p, output logic [31:0] npc,
                               output logic full);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    logic [31:0] imm_i;
    logic        valid;
    logic        taken;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm   = '0;
    valid = 1'b0;
    taken = 1'b0;
    p        = '0;
    p.rd     = w[11:7];
    p.op_a   = rs1;
    p.op_b   = rs2;
    p.alu_op = alu_add;
    p.mem_op = mem_none;
    npc      = pc + 32'd4;
    case (w[6:0])
      7'b0110011: begin
        valid    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        p.alu_op = alu_for(f3, f7[5]);
      end
      7'b0010011: begin
        if (f3 == 3'b001) valid = (f7 == 7'h00);
        else if (f3 == 3'b101) valid = (f7 == 7'h00 || f7 == 7'h20);
        else valid = 1'b1;
        // shift amount is zero extended
        imm      = (f3[1:0] == 2'b01) ? {27'b0, w[24:20]} : imm_i;
        p.alu_op = alu_for(f3, f3 == 3'b101 && f7[5]);
        p.op_b   = imm;
      end
      7'b0000011: begin
        imm   = imm_i;
        valid = 1'b1;
        case (f3)
          3'b000:  p.mem_op = mem_lb;
          3'b001:  p.mem_op = mem_lh;
          3'b010:  p.mem_op = mem_lw;
          3'b100:  p.mem_op = mem_lbu;
          3'b101:  p.mem_op = mem_lhu;
          default: valid = 1'b0;
        endcase
      end
      7'b0100011: begin
        imm   = {{20{w[31]}}, w[31:25], w[11:7]};
        p.rd  = '0;
        valid = (f3 <= 3'b010);
        p.mem_op = (f3 == 3'b000) ? mem_sb : (f3 == 3'b001) ? mem_sh : mem_sw;
      end
      7'b0110111, 7'b0010111: begin
        imm    = {w[31:12], 12'b0};
        valid  = 1'b1;
        p.op_a = w[5] ? 32'd0 : pc;
        p.op_b = imm;
      end
      7'b1101111: begin
        imm    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        valid  = 1'b1;
        p.op_a = pc;
        p.op_b = 32'd4;
        npc    = pc + imm;
      end
      7'b1100111: begin
        imm    = imm_i;
        valid  = (f3 == 3'b000);
        p.op_a = pc;
        p.op_b = 32'd4;
        npc    = (rs1 + imm) & 32'hffff_fffe;
      end
      7'b1100011: begin
        imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        valid  = (f3 != 3'b010 && f3 != 3'b011);
        p.rd   = '0;
        p.op_a = '0;
        p.op_b = '0;
        case (f3)
          3'b000:  taken = (rs1 == rs2);
          3'b001:  taken = (rs1 != rs2);
          3'b100:  taken = ($signed(rs1) < $signed(rs2));
          3'b101:  taken = ($signed(rs1) >= $signed(rs2));
          3'b110:  taken = (rs1 < rs2);
          default: taken = (rs1 >= rs2);
        endcase
        if (taken) npc = pc + imm;
      end
      default: valid = 1'b0;
    endcase
    p.mem_addr    = rs1 + imm;
    p.valid_instr = valid;
    full          = valid;
    if (!valid) begin
      p.mem_op = mem_none;
      npc      = pc + 32'd4;
    end
  endtask

  always @(posedge clk) begin
    if (have_expect) begin
      check_value("decode_valid", 32'(exp_dv), 32'(decode_valid));
      check_value("fetch_ready", 32'(exp_fr), 32'(fetch_ready));
      check_value("next_pc", exp_npc, next_pc);
      check_value("issue.valid_instr", 32'(exp_issue.valid_instr), 32'(issue.valid_instr));
      check_value("issue.mem_op", 32'(exp_issue.mem_op), 32'(issue.mem_op));
      if (exp_full) begin
        check_value("issue.op_a", exp_issue.op_a, issue.op_a);
        check_value("issue.op_b", exp_issue.op_b, issue.op_b);
        check_value("issue.mem_addr", exp_issue.mem_addr, issue.mem_addr);
        check_value("issue.rd", 32'(exp_issue.rd), 32'(issue.rd));
        check_value("issue.alu_op", 32'(exp_issue.alu_op), 32'(issue.alu_op));
      end
      check_value("rs1_addr", 32'(instr[19:15]), 32'(rs1_addr));
      check_value("rs2_addr", 32'(instr[24:20]), 32'(rs2_addr));
    end
    if (reset) begin
      exp_dv    = 1'b0;
      exp_fr    = 1'b0;
      exp_npc   = `RV_RESET_PC;
      exp_issue = '0;
      exp_full  = 1'b1;
    end else begin
      exp_fr = !fetch_valid && !exp_dv;
      // a stalled item is withdrawn
      if (!exec_ready) begin
        exp_dv = 1'b0;
      end else if (fetch_valid && !exp_dv) begin
        exp_dv = 1'b1;
      end
      if (fetch_valid) begin
        predict_issue(instr, fetch_pc, reg_rs1_data, reg_rs2_data, exp_issue, exp_npc, exp_full);
      end
    end
    have_expect = 1'b1;
  end

endmodule

// ==== rv_decode_top.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_top
  import rv_decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_valid,
  output logic                  fetch_ready,
  input  logic                  exec_ready,
  output logic                  decode_valid,
  input  logic [`RV_XLEN-1:0]   instr,
  input  logic [`RV_XLEN-1:0]   fetch_pc,
  input  logic [`RV_XLEN-1:0]   reg_rs1_data,
  input  logic [`RV_XLEN-1:0]   reg_rs2_data,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_XLEN-1:0]   next_pc,
  output issue_t                issue
);

  instr_word_u         instr_word;
  decoded_t            dec;
  logic [`RV_XLEN-1:0] imm;

  assign instr_word = instr;

  // register file read ports, same cycle as instr
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  instr_classify u_instr_classify (
    .instr (instr_word),
    .dec   (dec)
  );

  imm_gen u_imm_gen (
    .instr   (instr_word),
    .imm_fmt (dec.imm_fmt),
    .imm     (imm)
  );

  handshake_fsm u_handshake_fsm (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .exec_ready   (exec_ready),
    .decode_valid (decode_valid),
    .fetch_ready  (fetch_ready)
  );

  pc_unit u_pc_unit (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .dec         (dec),
    .imm         (imm),
    .rs1_data    (reg_rs1_data),
    .rs2_data    (reg_rs2_data),
    .next_pc     (next_pc)
  );

  issue_stage u_issue_stage (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .dec         (dec),
    .imm         (imm),
    .rs1_data    (reg_rs1_data),
    .rs2_data    (reg_rs2_data),
    .issue       (issue)
  );

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module issue_stage
  import rv_decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                fetch_valid,
  input  logic [`RV_XLEN-1:0] fetch_pc,
  input  decoded_t            dec,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output issue_t              issue
);

  logic                is_branch;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;

  // conditional branches only, jumps still link
  assign is_branch = dec.br_op inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

  always_comb begin
    if (is_branch || dec.zero_a) begin
      op_a = '0;
    end else if (dec.use_pc_a) begin
      op_a = fetch_pc;
    end else begin
      op_a = rs1_data;
    end
  end

  always_comb begin
    if (is_branch) begin
      op_b = '0;
    end else if (dec.link) begin
      op_b = `RV_PC_STEP;
    end else if (dec.use_imm_b) begin
      op_b = imm;
    end else begin
      // store data or the second register operand
      op_b = rs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      issue <= '0;
    end else if (fetch_valid) begin
      issue.op_a        <= op_a;
      issue.op_b        <= op_b;
      issue.mem_addr    <= rs1_data + imm;
      issue.rd          <= dec.rd;
      issue.alu_op      <= dec.alu_op;
      issue.mem_op      <= dec.mem_op;
      issue.valid_instr <= dec.valid;
    end
  end

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module pc_unit
  import rv_decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                fetch_valid,
  input  logic [`RV_XLEN-1:0] fetch_pc,
  input  decoded_t            dec,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic                taken;
  logic [`RV_XLEN-1:0] pc_seq;
  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] jalr_sum;
  logic [`RV_XLEN-1:0] pc_sel;

  always_comb begin
    case (dec.br_op)
      br_beq:  taken = (rs1_data == rs2_data);
      br_bne:  taken = (rs1_data != rs2_data);
      br_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      br_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      br_bltu: taken = (rs1_data < rs2_data);
      br_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign pc_seq   = fetch_pc + `RV_PC_STEP;
  assign pc_rel   = fetch_pc + imm;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if (dec.br_op == br_jalr) begin
      // jalr target has bit 0 cleared
      pc_sel = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else if (dec.br_op == br_jal || taken) begin
      pc_sel = pc_rel;
    end else begin
      pc_sel = pc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      next_pc <= `RV_RESET_PC;
    end else if (fetch_valid) begin
      next_pc <= pc_sel;
    end
  end

endmodule

// ==== handshake_fsm.sv ====
`timescale 1ns/1ps

module handshake_fsm (
  input  logic clk,
  input  logic reset,
  input  logic fetch_valid,
  input  logic exec_ready,
  output logic decode_valid,
  output logic fetch_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_issued
  } hs_state_e;

  hs_state_e state;
  hs_state_e state_next;

  always_comb begin
    case (state)
      // a stalled item is dropped, not held
      st_issued:
        state_next = exec_ready ? st_issued : st_idle;
      st_idle, st_request: begin
        if (fetch_valid && exec_ready) begin
          state_next = st_issued;
        end else if (!fetch_valid) begin
          state_next = st_request;
        end else begin
          state_next = st_idle;
        end
      end
      default:
        state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // outputs come straight from the state register
  assign decode_valid = (state == st_issued);
  assign fetch_ready  = (state == st_request);

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module imm_gen
  import rv_decode_pkg::*;
(
  input  instr_word_u         instr,
  input  imm_fmt_e            imm_fmt,
  output logic [`RV_XLEN-1:0] imm
);

  logic is_shift_imm;

  // slli, srli, srai
  assign is_shift_imm = (instr.i.opcode == opc_op_imm) && (instr.i.funct3[1:0] == 2'b01);

  always_comb begin
    case (imm_fmt)
      imm_i: begin
        if (is_shift_imm) begin
          imm = {{(`RV_XLEN-5){1'b0}}, instr.r.rs2};
        end else begin
          imm = {{(`RV_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        end
      end
      imm_s:
        imm = {{(`RV_XLEN-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      imm_b:
        imm = {{(`RV_XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
               instr.b.imm_4_1, 1'b0};
      imm_u:
        imm = {instr.u.imm_31_12, 12'b0};
      imm_j:
        imm = {{(`RV_XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
               instr.j.imm_10_1, 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

// ==== instr_classify.sv ====
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module instr_classify
  import rv_decode_pkg::*;
(
  input  instr_word_u instr,
  output decoded_t    dec
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_low;
  logic       f7_high;

  assign funct3  = instr.r.funct3;
  assign funct7  = instr.r.funct7;
  assign f7_low  = (funct7 == 7'b0000000);
  assign f7_high = (funct7 == 7'b0100000);

  // shared funct3 map of op and op_imm
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_decode = alt ? alu_sub : alu_add;
      3'b001:  alu_decode = alu_sll;
      3'b010:  alu_decode = alu_slt;
      3'b011:  alu_decode = alu_sltu;
      3'b100:  alu_decode = alu_xor;
      3'b101:  alu_decode = alt ? alu_sra : alu_srl;
      3'b110:  alu_decode = alu_or;
      default: alu_decode = alu_and;
    endcase
  endfunction

  always_comb begin
    dec     = '0;
    dec.rd  = instr.r.rd;
    dec.rs1 = instr.r.rs1;
    dec.rs2 = instr.r.rs2;

    case (instr.r.opcode)
      opc_op: begin
        dec.alu_op = alu_decode(funct3, funct7[5]);
        dec.valid  = f7_low || (f7_high && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      opc_op_imm: begin
        // only srai carries the alternate bit
        dec.alu_op    = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
        dec.imm_fmt   = imm_i;
        dec.use_imm_b = 1'b1;
        case (funct3)
          3'b001:  dec.valid = f7_low;
          3'b101:  dec.valid = f7_low || f7_high;
          default: dec.valid = 1'b1;
        endcase
      end
      opc_load: begin
        dec.imm_fmt = imm_i;
        dec.valid   = 1'b1;
        case (funct3)
          3'b000:  dec.mem_op = mem_lb;
          3'b001:  dec.mem_op = mem_lh;
          3'b010:  dec.mem_op = mem_lw;
          3'b100:  dec.mem_op = mem_lbu;
          3'b101:  dec.mem_op = mem_lhu;
          default: dec.valid  = 1'b0;
        endcase
      end
      opc_store: begin
        dec.imm_fmt = imm_s;
        dec.rd      = '0;
        dec.valid   = 1'b1;
        case (funct3)
          3'b000:  dec.mem_op = mem_sb;
          3'b001:  dec.mem_op = mem_sh;
          3'b010:  dec.mem_op = mem_sw;
          default: dec.valid  = 1'b0;
        endcase
      end
      opc_lui: begin
        // zero plus the upper immediate
        dec.imm_fmt   = imm_u;
        dec.zero_a    = 1'b1;
        dec.use_imm_b = 1'b1;
        dec.valid     = 1'b1;
      end
      opc_auipc: begin
        dec.imm_fmt   = imm_u;
        dec.use_pc_a  = 1'b1;
        dec.use_imm_b = 1'b1;
        dec.valid     = 1'b1;
      end
      opc_jal: begin
        dec.br_op    = br_jal;
        dec.imm_fmt  = imm_j;
        dec.use_pc_a = 1'b1;
        dec.link     = 1'b1;
        dec.valid    = 1'b1;
      end
      opc_jalr: begin
        dec.br_op    = br_jalr;
        dec.imm_fmt  = imm_i;
        dec.use_pc_a = 1'b1;
        dec.link     = 1'b1;
        dec.valid    = (funct3 == 3'b000);
      end
      opc_branch: begin
        dec.imm_fmt = imm_b;
        dec.rd      = '0;
        dec.valid   = 1'b1;
        case (funct3)
          3'b000:  dec.br_op = br_beq;
          3'b001:  dec.br_op = br_bne;
          3'b100:  dec.br_op = br_blt;
          3'b101:  dec.br_op = br_bge;
          3'b110:  dec.br_op = br_bltu;
          3'b111:  dec.br_op = br_bgeu;
          default: dec.valid = 1'b0;
        endcase
      end
      default: dec.valid = 1'b0;
    endcase

    // unrecognized words decode as a plain nop
    if (!dec.valid) begin
      dec.alu_op    = alu_add;
      dec.mem_op    = mem_none;
      dec.br_op     = br_none;
      dec.imm_fmt   = imm_none;
      dec.use_imm_b = 1'b0;
      dec.use_pc_a  = 1'b0;
      dec.zero_a    = 1'b0;
      dec.link      = 1'b0;
    end
  end

endmodule

// ==== rv_decode_pkg.sv ====
`include "rv_decode_settings.svh"

package rv_decode_pkg;

  // kept major opcodes, low two bits always 2'b11
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_slt, alu_sltu, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  // nine values, so one bit wider than the branch funct3
  typedef enum logic [3:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr
  } br_op_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    opcode_e               opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } j_fmt_t;

  // one instruction word, six views of its fields
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_word_u;

  typedef struct packed {
    alu_op_e               alu_op;
    mem_op_e               mem_op;
    br_op_e                br_op;
    imm_fmt_e              imm_fmt;
    logic                  use_imm_b;
    logic                  use_pc_a;
    logic                  zero_a;
    logic                  link;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic                  valid;
  } decoded_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   mem_addr;
    logic [`RV_REG_AW-1:0] rd;
    alu_op_e               alu_op;
    mem_op_e               mem_op;
    logic                  valid_instr;
  } issue_t;

endpackage

// ==== rv_decode_settings.svh ====
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// data path and pc width
`define RV_XLEN 32

// register file address width
`define RV_REG_AW 5

// sequential pc increment, no compressed instructions
`define RV_PC_STEP 32'd4

// next_pc value out of reset
`define RV_RESET_PC 32'h0000_0000

`endif
